// ==== source/axil_pkg.sv ====
// AXI4-Lite channel payload types and response codes, imported by the slave and its testbench.
package axil_pkg;

    localparam int AXIL_ADDR_BITS = 32;                 // Byte address width.
    localparam int AXIL_DATA_BITS = 32;
    localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8; // One strobe per byte lane.

    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t AXIL_OKAY   = 2'b00;
    localparam axil_resp_t AXIL_SLVERR = 2'b10;

    // Write address channel.
    typedef struct packed {
        logic [AXIL_ADDR_BITS-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [AXIL_DATA_BITS-1:0] data;
        logic [AXIL_STRB_BITS-1:0] strb;
    } axil_w_t;

    // Read address channel.
    typedef struct packed {
        logic [AXIL_ADDR_BITS-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [AXIL_DATA_BITS-1:0] data;
        axil_resp_t                resp;  // OKAY or SLVERR.
    } axil_r_t;

endpackage

// ==== source/bram_pkg.sv ====
// Block RAM word geometry and the command format passed from the AXI front end to the RAM port.
package bram_pkg;

    localparam int BRAM_DATA_BITS      = 32;
    localparam int BRAM_STRB_BITS      = 4;   // Byte enables per word.
    localparam int BRAM_WORD_ADDR_BITS = 30;  // Word address of a 32-bit byte address.

    // One RAM access.
    // A read carries a zero strobe; a write with a zero strobe changes nothing.
    typedef struct packed {
        logic                           read;
        logic [BRAM_STRB_BITS-1:0]      strb;
        logic [BRAM_WORD_ADDR_BITS-1:0] addr;  // Cut down to the RAM depth at the port.
        logic [BRAM_DATA_BITS-1:0]      data;
        logic                           err;   // Address is outside the RAM.
    } bram_cmd_t;

endpackage

// ==== source/axil_command_stage.sv ====
// AXI4-Lite front end: holds one read and one write, range checks them and issues RAM commands.
`timescale 1ns/100ps

module axil_command_stage
    import axil_pkg::*;
    import bram_pkg::*;
#(
    parameter int ADDR_BITS = 10
) (
    input  logic       bram,
    input  logic       reset,

    input  logic       aw_valid,
    output logic       aw_ready,
    input  axil_aw_t   aw,
    input  logic       w_valid,
    output logic       w_ready,
    input  axil_w_t    w,
    output logic       b_valid,
    input  logic       b_ready,
    output axil_resp_t b_resp,
    input  logic       ar_valid,
    output logic       ar_ready,
    input  axil_ar_t   ar,

    output bram_cmd_t  cmd,
    output logic       cmd_valid,
    input  logic       cmd_ready
);

    logic      rd_pend;       // Read holding register full.
    logic      wr_pend;       // Write holding register full.
    logic      rd_prio;       // Read wins the next tie.
    logic      ar_open;
    logic      wr_open;
    bram_cmd_t rd_cmd;
    bram_cmd_t wr_cmd;

    logic      ar_hs;
    logic      aw_hs;
    logic      cmd_hs;
    logic      rd_sel;
    logic      ar_err;
    logic      aw_err;
    logic      rd_pend_next;
    logic      wr_pend_next;
    logic      b_valid_next;

    // AW and W are taken in the same cycle or not at all.
    assign ar_ready = ar_open;
    assign aw_ready = wr_open && aw_valid && w_valid;
    assign w_ready  = aw_ready;

    assign ar_hs = ar_valid && ar_ready;
    assign aw_hs = aw_ready;

    // Any word address bit at or above ADDR_BITS lies past the end of the RAM.
    assign ar_err = |(ar.addr[31:2] >> ADDR_BITS);
    assign aw_err = |(aw.addr[31:2] >> ADDR_BITS);

    assign rd_sel    = rd_pend && (!wr_pend || rd_prio);
    assign cmd_valid = rd_pend || wr_pend;
    assign cmd       = rd_sel ? rd_cmd : wr_cmd;
    assign cmd_hs    = cmd_valid && cmd_ready;

    assign rd_pend_next = ar_hs || (rd_pend && !(cmd_hs && rd_sel));
    assign wr_pend_next = aw_hs || (wr_pend && !(cmd_hs && !rd_sel));
    assign b_valid_next = (cmd_hs && !rd_sel) || (b_valid && !b_ready);

    always_ff @(posedge bram) begin
        if (reset) begin
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
            b_valid <= 1'b0;
            rd_prio <= 1'b1;  // First tie goes to the read.
            ar_open <= 1'b0;
            wr_open <= 1'b0;
        end else begin
            rd_pend <= rd_pend_next;
            wr_pend <= wr_pend_next;
            b_valid <= b_valid_next;
            ar_open <= !rd_pend_next;
            wr_open <= !wr_pend_next && !b_valid_next;  // One write in flight, B included.
            if (cmd_hs) begin
                rd_prio <= !rd_sel;  // Hand priority to the other side.
            end
        end
    end

    always_ff @(posedge bram) begin
        if (ar_hs) begin
            rd_cmd <= '{read: 1'b1, strb: '0, addr: ar.addr[31:2], data: '0, err: ar_err};
        end
        if (aw_hs) begin
            wr_cmd <= '{read: 1'b0,
                        strb: aw_err ? '0 : w.strb,  // Nothing is written out of range.
                        addr: aw.addr[31:2],
                        data: w.data,
                        err:  aw_err};
        end
        if (cmd_hs && !rd_sel) begin
            b_resp <= wr_cmd.err ? AXIL_SLVERR : AXIL_OKAY;
        end
    end

endmodule

// ==== source/bram_accessor.sv ====
// RAM port driver: turns commands into RAM enables and tracks reads to the AXI R channel.
`timescale 1ns/100ps

module bram_accessor
    import axil_pkg::*;
    import bram_pkg::*;
#(
    parameter int ADDR_BITS = 10,
    parameter int RLATENCY  = 2
) (
    input  logic                      bram,
    input  logic                      reset,

    input  bram_cmd_t                 cmd,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,

    output logic                      r_valid,
    input  logic                      r_ready,
    output axil_r_t                   r,

    output logic [RLATENCY-1:0]       en,
    output logic [BRAM_STRB_BITS-1:0] we,
    output logic [ADDR_BITS-1:0]      addr,
    output logic [BRAM_DATA_BITS-1:0] wdata,
    input  logic [BRAM_DATA_BITS-1:0] rdata
);

    logic [RLATENCY-1:0] pipe_valid;  // A read sits in this stage.
    logic [RLATENCY-1:0] pipe_err;    // That read was out of range.
    logic [RLATENCY:0]   valid_in;
    logic [RLATENCY:0]   err_in;
    logic [RLATENCY:0]   fetch_in;
    logic                access;

    // The pipeline only moves when the R output can take a new word.
    assign cmd_ready = !r_valid || r_ready;
    assign access    = cmd_valid && !cmd.err;

    assign valid_in = {pipe_valid, cmd_valid && cmd.read};
    assign err_in   = {pipe_err, cmd.err};
    assign fetch_in = {pipe_valid & ~pipe_err, access};  // Stages holding real RAM data.

    always_ff @(posedge bram) begin
        if (reset) begin
            pipe_valid <= '0;
        end else if (cmd_ready) begin
            pipe_valid <= valid_in[RLATENCY-1:0];
        end
    end

    always_ff @(posedge bram) begin
        if (cmd_ready) begin
            pipe_err <= err_in[RLATENCY-1:0];
        end
    end

    // Each read register is clocked only when a live read moves into it.
    assign en    = {RLATENCY{cmd_ready}} & fetch_in[RLATENCY-1:0];
    assign we    = en[0] ? cmd.strb : '0;
    assign addr  = cmd.addr[ADDR_BITS-1:0];  // Upper bits already checked by err.
    assign wdata = cmd.data;

    assign r_valid = pipe_valid[RLATENCY-1];

    always_comb begin
        r.data = pipe_err[RLATENCY-1] ? '0 : rdata;
        r.resp = pipe_err[RLATENCY-1] ? AXIL_SLVERR : AXIL_OKAY;
    end

endmodule

// ==== source/bram_array.sv ====
// Byte-writable single-port RAM with a clock-enabled read register chain, driven by the accessor.
`timescale 1ns/100ps

module bram_array
    import bram_pkg::*;
#(
    parameter int ADDR_BITS = 10,
    parameter int RLATENCY  = 2
) (
    input  logic                      bram,
    input  logic [RLATENCY-1:0]       en,
    input  logic [BRAM_STRB_BITS-1:0] we,
    input  logic [ADDR_BITS-1:0]      addr,
    input  logic [BRAM_DATA_BITS-1:0] wdata,
    output logic [BRAM_DATA_BITS-1:0] rdata
);

    localparam int DEPTH     = 2 ** ADDR_BITS;
    localparam int BYTE_BITS = BRAM_DATA_BITS / BRAM_STRB_BITS;

    logic [BRAM_DATA_BITS-1:0] mem     [DEPTH];
    logic [BRAM_DATA_BITS-1:0] rd_pipe [RLATENCY];

    // Port access; a read in the same cycle as a write returns the old word.
    always_ff @(posedge bram) begin
        if (en[0]) begin
            for (int b = 0; b < BRAM_STRB_BITS; b++) begin
                if (we[b]) begin
                    mem[addr][b*BYTE_BITS +: BYTE_BITS] <= wdata[b*BYTE_BITS +: BYTE_BITS];
                end
            end
            rd_pipe[0] <= mem[addr];
        end
    end

    // Output registers, each with its own enable.
    always_ff @(posedge bram) begin
        for (int i = 1; i < RLATENCY; i++) begin
            if (en[i]) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    assign rdata = rd_pipe[RLATENCY-1];

endmodule

// ==== source/bram_axil_top.sv ====
// AXI4-Lite slave giving word access to a block RAM; instantiate this as the DUT.
`timescale 1ns/100ps

module bram_axil_top
    import axil_pkg::*;
    import bram_pkg::*;
#(
    parameter int ADDR_BITS = 10,  // RAM holds 2**ADDR_BITS words.
    parameter int RLATENCY  = 2
) (
    input  logic       bram,
    input  logic       reset,

    input  logic       aw_valid,
    output logic       aw_ready,
    input  axil_aw_t   aw,
    input  logic       w_valid,
    output logic       w_ready,
    input  axil_w_t    w,
    output logic       b_valid,
    input  logic       b_ready,
    output axil_resp_t b_resp,
    input  logic       ar_valid,
    output logic       ar_ready,
    input  axil_ar_t   ar,
    output logic       r_valid,
    input  logic       r_ready,
    output axil_r_t    r
);

    bram_cmd_t                 cmd;
    logic                      cmd_valid;
    logic                      cmd_ready;
    logic [RLATENCY-1:0]       en;
    logic [BRAM_STRB_BITS-1:0] we;
    logic [ADDR_BITS-1:0]      addr;
    logic [BRAM_DATA_BITS-1:0] wdata;
    logic [BRAM_DATA_BITS-1:0] rdata;

    axil_command_stage #(
        .ADDR_BITS (ADDR_BITS)
    ) u_command (
        .bram      (bram),
        .reset     (reset),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b_resp    (b_resp),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

    bram_accessor #(
        .ADDR_BITS (ADDR_BITS),
        .RLATENCY  (RLATENCY)
    ) u_accessor (
        .bram      (bram),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .en        (en),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata)
    );

    bram_array #(
        .ADDR_BITS (ADDR_BITS),
        .RLATENCY  (RLATENCY)
    ) u_array (
        .bram  (bram),
        .en    (en),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata)
    );

endmodule

// ==== testbench/bram_axil_checker.sv ====
// Assertions on the BRAM accessor's R channel and RAM port, bound into every bram_accessor.
`timescale 1ns/100ps

module bram_axil_checker
    import axil_pkg::*;
    import bram_pkg::*;
#(
    parameter int RLATENCY = 2
) (
    input logic                      bram,
    input logic                      reset,
    input bram_cmd_t                 cmd,
    input logic                      r_valid,
    input logic                      r_ready,
    input axil_r_t                   r,
    input logic [RLATENCY-1:0]       en,
    input logic [BRAM_STRB_BITS-1:0] we
);

    // A stalled R beat stays put.
    r_hold: assert property (@(posedge bram) disable iff (reset)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R channel changed while r_ready was low");

    // Idle cycles and reads never write the RAM.
    we_gated: assert property (@(posedge bram) disable iff (reset)
        !en[0] || cmd.read |-> we == '0)
        else $error("Byte write enable set with the RAM port disabled or on a read");

    r_idle_after_reset: assert property (@(posedge bram) reset |=> !r_valid)
        else $error("r_valid high in the cycle after reset");

endmodule

bind bram_accessor bram_axil_checker #(.RLATENCY(RLATENCY)) u_checker (
    .bram    (bram),
    .reset   (reset),
    .cmd     (cmd),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .r       (r),
    .en      (en),
    .we      (we)
);

// ==== testbench/tb_bram_axil.sv ====
// Directed testbench for the AXI4-Lite BRAM slave; compile with src.f and run tb_bram_axil as top.
`timescale 1ns/100ps

module tb_bram_axil
    import axil_pkg::*;
();

    localparam int ADDR_BITS   = 8;
    localparam int RLATENCY    = 2;
    localparam int WORDS       = 2 ** ADDR_BITS;
    localparam int NUM_WORDS   = 8;      // Words touched by each test.
    localparam int WATCHDOG_NS = 20000;  // Several times the length of all tests together.

    logic       bram;
    logic       reset;
    logic       aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic       ar_valid, ar_ready, r_valid, r_ready;
    axil_aw_t   aw;
    axil_w_t    w;
    axil_ar_t   ar;
    axil_resp_t b_resp;
    axil_r_t    r;

    logic [31:0] ref_mem [WORDS];  // Expected RAM contents.
    axil_r_t     exp_q [$];        // Expected R beats, in AR order.
    integer      seed = 32'ha25b_98c4;
    int          errors = 0;
    int          checks = 0;

    bram_axil_top #(.ADDR_BITS(ADDR_BITS), .RLATENCY(RLATENCY)) dut (.*);

    initial bram = 1'b0;
    always #5 bram = ~bram;

    // Sends one write and checks B; the reference is updated once B is seen.
    task automatic write_word(input logic [31:0] byte_addr, input logic [31:0] data,
                              input logic [3:0] strb);
        axil_resp_t want;
        logic       in_range;
        in_range = byte_addr < 4 * WORDS;
        want     = in_range ? AXIL_OKAY : AXIL_SLVERR;
        @(negedge bram);
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        aw.addr  = byte_addr;
        w.data   = data;
        w.strb   = strb;
        b_ready  = 1'b1;
        #1;
        while (!aw_ready) begin
            @(negedge bram);
            #1;
        end
        checks++;
        if (w_ready !== 1'b1) begin  // AW and W go in together.
            errors++;
            $display("FAILED at %0t ns: w_ready = %b, expected 1", $time, w_ready);
        end
        @(negedge bram);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        #1;
        while (!b_valid) begin
            @(negedge bram);
            #1;
        end
        checks++;
        if (b_resp !== want) begin
            errors++;
            $display("FAILED at %0t ns: b_resp = %h, expected %h", $time, b_resp, want);
        end
        for (int b = 0; b < 4; b++) begin
            if (in_range && strb[b]) begin
                ref_mem[byte_addr[ADDR_BITS+1:2]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    // Sends one AR and queues the beat expected from the reference at the handshake.
    task automatic send_ar(input logic [31:0] byte_addr);
        axil_r_t want;
        @(negedge bram);
        ar_valid = 1'b1;
        ar.addr  = byte_addr;
        #1;
        while (!ar_ready) begin
            @(negedge bram);
            #1;
        end
        want.data = (byte_addr < 4 * WORDS) ? ref_mem[byte_addr[ADDR_BITS+1:2]] : '0;
        want.resp = (byte_addr < 4 * WORDS) ? AXIL_OKAY : AXIL_SLVERR;
        exp_q.push_back(want);
        @(negedge bram);
        ar_valid = 1'b0;
    endtask

    // Takes one R beat; with stall set, r_ready is random each cycle.
    task automatic recv_r(input logic stall);
        axil_r_t     want;
        logic [31:0] roll;
        logic        taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge bram);
            roll    = $random(seed);
            r_ready = stall ? roll[0] : 1'b1;
            #1;
            taken = r_valid && r_ready;
        end
        if (exp_q.size() == 0) begin
            errors++;
            $display("An R beat arrived at %0t ns with no read outstanding", $time);
        end else begin
            want   = exp_q.pop_front();
            checks += 2;
            if (r.data !== want.data) begin
                errors++;
                $display("FAILED at %0t ns: r.data = %h, expected %h", $time, r.data, want.data);
            end
            if (r.resp !== want.resp) begin
                errors++;
                $display("FAILED at %0t ns: r.resp = %h, expected %h", $time, r.resp, want.resp);
            end
        end
    endtask

    task automatic read_word(input logic [31:0] byte_addr);
        send_ar(byte_addr);
        recv_r(1'b0);
    endtask

    task automatic full_word_roundtrip();
        for (int i = 0; i < NUM_WORDS; i++) write_word(4 * i, $random(seed), 4'hf);
        for (int i = 0; i < NUM_WORDS; i++) read_word(4 * i);
    endtask

    task automatic partial_strobe_writes();
        logic [31:0] roll;
        for (int i = 0; i < NUM_WORDS; i++) begin
            roll = $random(seed);
            write_word(4 * i, $random(seed), roll[3:0]);
        end
        for (int i = 0; i < NUM_WORDS; i++) read_word(4 * i);
    endtask

    task automatic out_of_range_access();
        read_word(32'd1024);
        read_word(32'h8000_0000);
        write_word(32'd1024, 32'hdead_beef, 4'hf);  // Aliases word 0 without the range check.
        write_word(32'd1028, 32'h1234_5678, 4'hf);
        read_word(32'd0);
        read_word(32'd4);
    endtask

    task automatic backpressured_reads();
        fork
            for (int i = 0; i < 2 * NUM_WORDS; i++) send_ar(4 * (i % NUM_WORDS));
            for (int i = 0; i < 2 * NUM_WORDS; i++) recv_r(1'b1);
        join
    endtask

    // Writes go to words 16 and up while reads cover words 0 to 7.
    task automatic interleaved_traffic();
        fork
            for (int i = 0; i < NUM_WORDS; i++) write_word(4 * (16 + i), $random(seed), 4'hf);
            for (int i = 0; i < NUM_WORDS; i++) read_word(4 * i);
        join
        for (int i = 0; i < NUM_WORDS; i++) read_word(4 * (16 + i));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns with the tests still running", $time);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw       = '0;
        w        = '0;
        ar       = '0;
        repeat (10) @(negedge bram);
        reset = 1'b0;
        full_word_roundtrip();
        partial_strobe_writes();
        out_of_range_access();
        backpressured_reads();
        interleaved_traffic();
        repeat (5) @(negedge bram);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d reads never returned data", exp_q.size());
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/axil_pkg.sv
source/bram_pkg.sv
source/axil_command_stage.sv
source/bram_accessor.sv
source/bram_array.sv
source/bram_axil_top.sv
testbench/bram_axil_checker.sv
testbench/tb_bram_axil.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module tb_bram_axil -Mdir obj_dir -o sim_bram_axil
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_bram_axil > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
